// ==== d_cache_tq.f ====
tq_pkg.sv
tq_entry_fsm.sv
tq_occupancy.sv
tq_merge_buffer.sv
tq_pipe_port.sv
d_cache_tq.sv
tb_d_cache_tq.sv

// ==== Bender.yml ====
package:
  name: d_cache_tq

sources:
  - tq_pkg.sv
  - tq_entry_fsm.sv
  - tq_occupancy.sv
  - tq_merge_buffer.sv
  - tq_pipe_port.sv
  - d_cache_tq.sv
  - target: simulation
    files:
      - tb_d_cache_tq.sv

// ==== tb_d_cache_tq.sv ====
// testbench for the data cache transaction queue
// random core traffic against a lookup pipe model, a far-memory model
// and a reference model of the queue entries
`default_nettype none

module tb_d_cache_tq;
    import tq_pkg::*;

    localparam int N_REQ       = 400;
    localparam int CYCLE_LIMIT = 2 * N_REQ * 20;

    logic      clk;
    logic      rst_n;
    t_core_req core_req;
    logic      stall;
    t_core_rsp core_rsp;
    t_fm_rsp   fm_rsp;
    t_lu_req   lu_req_q1;
    t_lu_rsp   lu_rsp_q3;

    logic [31:0] seed;
    int          cycle;
    int          sent;

    // ==============================
    // queue model
    // ==============================
    t_tq_state    st      [NUM_TQ_ENTRY];
    t_cl          mline   [NUM_TQ_ENTRY];
    t_word_mask   mmask   [NUM_TQ_ENTRY];
    t_cl_address  mcla    [NUM_TQ_ENTRY];
    t_word_offset moff    [NUM_TQ_ENTRY];
    t_reg_id      mreg    [NUM_TQ_ENTRY];
    logic         mrd     [NUM_TQ_ENTRY];
    int           fm_wait [NUM_TQ_ENTRY];  // -1 no miss out, 0 fill due
    int           busy;                    // registered count, one cycle behind
    t_lu_rsp      pipe_q2;                 // lookup sent last cycle
    t_lu_rsp      pipe_q3;                 // answer driven this cycle

    d_cache_tq uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .core_req  (core_req),
        .stall     (stall),
        .core_rsp  (core_rsp),
        .fm_rsp    (fm_rsp),
        .lu_req_q1 (lu_req_q1),
        .lu_rsp_q3 (lu_rsp_q3)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function t_cl rand_line();
        t_cl l;
        for (int w = 0; w < WORDS_IN_CL; w++) l[w] = lcg_next();
        return l;
    endfunction

    task automatic check_equal(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        if (exp !== act) begin
            $display("** Error: %s at cycle %0d, expected %0h, actual %0h",
                     name, cycle, exp, act);
            $display("Some tests failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // one clock of stimulus, checks and model update
    task automatic run_cycle(input bit allow_req);
        t_core_req    req;
        t_fm_rsp      fm;
        t_lu_rsp      rsp;
        t_lu_req      exp_req;
        t_core_rsp    exp_rsp;
        t_cl_address  cla;
        t_word_offset off;
        logic         stall_exp;
        logic [31:0]  r;
        int           hit_id;
        int           alloc_id;
        int           grant_id;

        @(negedge clk);
        stall_exp = (busy >= NUM_TQ_ENTRY - 1);
        check_equal("stall", stall_exp, stall);

        // far memory, lowest due entry first
        fm = '0;
        for (int i = 0; i < NUM_TQ_ENTRY; i++) if (fm_wait[i] > 0) fm_wait[i]--;
        for (int i = NUM_TQ_ENTRY - 1; i >= 0; i--) begin
            if (fm_wait[i] == 0) begin
                fm.valid = 1'b1;
                fm.tq_id = t_tq_id'(i);
            end
        end
        if (fm.valid) begin
            fm.cl_data      = rand_line();
            fm_wait[fm.tq_id] = -1;
        end

        rsp = pipe_q3;
        req = '0;
        r   = lcg_next();
        if (allow_req && !stall_exp && r[1:0] != 2'b00) begin
            req.valid   = 1'b1;
            req.opcode  = r[2] ? WR_OP : RD_OP;
            req.address = {14'h12a4, r[5:4], r[7:6], r[9:8]};   // 4 lines only
            req.data    = lcg_next();
            req.reg_id  = r[14:10];
            sent++;
        end
        core_req  = req;
        fm_rsp    = fm;
        lu_rsp_q3 = rsp;
        #1;

        cla      = req.address[19:4];
        off      = req.address[3:2];
        hit_id   = -1;
        alloc_id = -1;
        grant_id = -1;
        for (int i = NUM_TQ_ENTRY - 1; i >= 0; i--) begin
            if ((st[i] == S_MB_WAIT_FILL || st[i] == S_MB_FILL_READY) && !mrd[i]
                && mcla[i] == cla && req.valid && req.opcode == WR_OP) hit_id = i;
            if (st[i] == S_IDLE) alloc_id = i;
            if (st[i] == S_MB_FILL_READY) grant_id = i;
        end
        if (!req.valid || hit_id >= 0) alloc_id = -1;
        if (req.valid) grant_id = -1;           // core owns the pipe slot

        exp_req = '0;
        if (req.valid) begin
            exp_req.valid         = 1'b1;
            exp_req.lu_op         = (req.opcode == WR_OP) ? WR_LU : RD_LU;
            exp_req.address       = req.address;
            exp_req.data          = req.data;
            exp_req.tq_id         = t_tq_id'((hit_id >= 0) ? hit_id : alloc_id);
            exp_req.mb_hit_cancel = (hit_id >= 0);
            exp_req.rd_indication = (req.opcode == RD_OP);
            exp_req.wr_indication = (req.opcode == WR_OP);
            exp_req.reg_id        = req.reg_id;
        end else if (grant_id >= 0) begin
            exp_req.valid         = 1'b1;
            exp_req.lu_op         = FILL_LU;
            exp_req.address       = {mcla[grant_id], moff[grant_id], 2'b00};
            exp_req.cl_data       = mline[grant_id];
            exp_req.tq_id         = t_tq_id'(grant_id);
            exp_req.rd_indication = mrd[grant_id];
            exp_req.wr_indication = !mrd[grant_id];
            exp_req.reg_id        = mreg[grant_id];
        end
        check_equal("lu_req_q1", exp_req, lu_req_q1);

        // read hit or read fill returns the addressed word
        exp_rsp = '0;
        if (rsp.valid && ((rsp.lu_op == RD_LU && rsp.lu_result == HIT)
                          || (rsp.lu_op == FILL_LU && rsp.rd_indication))) begin
            exp_rsp.valid   = 1'b1;
            exp_rsp.data    = rsp.cl_data[rsp.address[3:2]];
            exp_rsp.address = rsp.address;
            exp_rsp.reg_id  = rsp.reg_id;
            check_equal("core_rsp", exp_rsp, core_rsp);
        end else begin
            check_equal("core_rsp.valid", 1'b0, core_rsp.valid);
        end

        // ==============================
        // model update at the edge
        // ==============================
        if (alloc_id >= 0) begin
            st[alloc_id]    = S_LU_CORE;
            mcla[alloc_id]  = cla;
            moff[alloc_id]  = off;
            mreg[alloc_id]  = req.reg_id;
            mrd[alloc_id]   = (req.opcode == RD_OP);
            mmask[alloc_id] = '0;
            busy++;
        end
        if ((alloc_id >= 0 && req.opcode == WR_OP) || hit_id >= 0) begin
            mline[(hit_id >= 0) ? hit_id : alloc_id][off] = req.data;
            mmask[(hit_id >= 0) ? hit_id : alloc_id][off] = 1'b1;
        end
        if (fm.valid) begin                     // written words stay on top
            for (int w = 0; w < WORDS_IN_CL; w++)
                if (!mmask[fm.tq_id][w]) mline[fm.tq_id][w] = fm.cl_data[w];
            st[fm.tq_id] = S_MB_FILL_READY;
        end
        if (grant_id >= 0) begin
            st[grant_id] = S_IDLE;
            busy--;
        end
        if (rsp.valid && rsp.lu_op != FILL_LU) begin
            if (rsp.lu_result == HIT) begin
                st[rsp.tq_id] = S_IDLE;
                busy--;
            end else begin
                st[rsp.tq_id]      = S_MB_WAIT_FILL;
                fm_wait[rsp.tq_id] = 1 + lcg_next() % 6;   // 1 to 6 cycles
            end
        end

        // pipe model, merged writes get no answer
        pipe_q3 = pipe_q2;
        pipe_q2 = '0;
        if (exp_req.valid && !exp_req.mb_hit_cancel) begin
            r                     = lcg_next();
            pipe_q2.valid         = 1'b1;
            pipe_q2.lu_op         = exp_req.lu_op;
            pipe_q2.tq_id         = exp_req.tq_id;
            pipe_q2.address       = exp_req.address;
            pipe_q2.rd_indication = exp_req.rd_indication;
            pipe_q2.reg_id        = exp_req.reg_id;
            if (exp_req.lu_op == FILL_LU) begin
                pipe_q2.lu_result = HIT;
                pipe_q2.cl_data   = exp_req.cl_data;   // line as written into the cache
            end else begin
                pipe_q2.lu_result = (r[1:0] != 2'b00) ? MISS : HIT;  // misses favored
                pipe_q2.cl_data   = rand_line();
            end
        end
    endtask

    initial begin
        seed      = 32'h038a6217;
        rst_n     = 1'b0;
        core_req  = '0;
        fm_rsp    = '0;
        lu_rsp_q3 = '0;
        cycle     = 0;
        sent      = 0;
        busy      = 0;
        pipe_q2   = '0;
        pipe_q3   = '0;
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            st[i]      = S_IDLE;
            mline[i]   = '0;
            mmask[i]   = '0;
            mcla[i]    = '0;
            moff[i]    = '0;
            mreg[i]    = '0;
            mrd[i]     = 1'b0;
            fm_wait[i] = -1;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_equal("reset stall", 1'b0, stall);
        check_equal("reset lu_req_q1.valid", 1'b0, lu_req_q1.valid);
        check_equal("reset core_rsp.valid", 1'b0, core_rsp.valid);

        // traffic, then drain until the queue and the pipe are empty
        while (sent < N_REQ || busy != 0 || pipe_q2.valid || pipe_q3.valid) begin
            if (cycle >= CYCLE_LIMIT) begin
                $display("timeout: queue did not drain within %0d cycles", CYCLE_LIMIT);
                $display("Some tests failed");
                $fatal(1, "timeout");
            end
            run_cycle(sent < N_REQ);
            cycle++;
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== d_cache_tq.sv ====
// data cache transaction queue
// four outstanding core transactions between the core and the cache lookup pipe
`default_nettype none

module d_cache_tq (
    input  wire                   clk,
    input  wire                   rst_n,
    // core side
    input  var tq_pkg::t_core_req core_req,
    output logic                  stall,
    output tq_pkg::t_core_rsp     core_rsp,
    // far memory
    input  var tq_pkg::t_fm_rsp   fm_rsp,
    // lookup pipe
    output tq_pkg::t_lu_req       lu_req_q1,
    input  var tq_pkg::t_lu_rsp   lu_rsp_q3
);
    import tq_pkg::*;

    t_entry_vec alloc_vec;
    t_entry_vec retire_vec;
    t_entry_vec fill_ready_vec;
    t_entry_vec merge_ok_vec;
    t_entry_vec fill_load_vec;
    t_entry_vec wr_hit_vec;
    t_entry_vec fill_grant_vec;
    t_entry_vec lu_hit_vec;
    t_entry_vec lu_miss_vec;
    t_mb_entry [NUM_TQ_ENTRY-1:0] mb_entries;

    tq_entry_fsm u_entry_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req       (core_req),
        .wr_hit_vec     (wr_hit_vec),
        .lu_hit_vec     (lu_hit_vec),
        .lu_miss_vec    (lu_miss_vec),
        .fill_grant_vec (fill_grant_vec),
        .fm_rsp         (fm_rsp),
        .alloc_vec      (alloc_vec),
        .retire_vec     (retire_vec),
        .fill_ready_vec (fill_ready_vec),
        .merge_ok_vec   (merge_ok_vec),
        .fill_load_vec  (fill_load_vec)
    );

    tq_occupancy u_occupancy (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_vec  (alloc_vec),
        .retire_vec (retire_vec),
        .core_valid (core_req.valid),
        .stall      (stall)
    );

    tq_merge_buffer u_merge_buffer (
        .clk           (clk),
        .core_req      (core_req),
        .alloc_vec     (alloc_vec),
        .merge_ok_vec  (merge_ok_vec),
        .fill_load_vec (fill_load_vec),
        .fm_rsp        (fm_rsp),
        .wr_hit_vec    (wr_hit_vec),
        .mb_entries    (mb_entries)
    );

    tq_pipe_port u_pipe_port (
        .core_req       (core_req),
        .alloc_vec      (alloc_vec),
        .wr_hit_vec     (wr_hit_vec),
        .fill_ready_vec (fill_ready_vec),
        .mb_entries     (mb_entries),
        .lu_rsp_q3      (lu_rsp_q3),
        .lu_req_q1      (lu_req_q1),
        .fill_grant_vec (fill_grant_vec),
        .lu_hit_vec     (lu_hit_vec),
        .lu_miss_vec    (lu_miss_vec),
        .core_rsp       (core_rsp)
    );

endmodule

`default_nettype wire

// ==== tq_pipe_port.sv ====
// transaction queue pipe port
// lookup request mux, response decode into entry events, core read response
`default_nettype none

module tq_pipe_port (
    input  var tq_pkg::t_core_req  core_req,
    input  var tq_pkg::t_entry_vec alloc_vec,
    input  var tq_pkg::t_entry_vec wr_hit_vec,
    input  var tq_pkg::t_entry_vec fill_ready_vec,
    input  var tq_pkg::t_mb_entry [tq_pkg::NUM_TQ_ENTRY-1:0] mb_entries,
    input  var tq_pkg::t_lu_rsp    lu_rsp_q3,
    output tq_pkg::t_lu_req        lu_req_q1,
    output tq_pkg::t_entry_vec     fill_grant_vec,
    output tq_pkg::t_entry_vec     lu_hit_vec,
    output tq_pkg::t_entry_vec     lu_miss_vec,
    output tq_pkg::t_core_rsp      core_rsp
);
    import tq_pkg::*;

    logic   wr_hit_any;
    t_tq_id fill_id;
    logic   core_lu_rsp;   // rd or wr lookup answer
    logic   rd_hit_rsp;
    logic   fill_rd_rsp;

    assign wr_hit_any = |wr_hit_vec;

    // fills only use cycles the core leaves empty
    assign fill_grant_vec = core_req.valid ? '0 : first_one(fill_ready_vec);
    assign fill_id        = encode(fill_grant_vec);

    // ==============================
    // lookup request q1
    // ==============================
    always_comb begin
        lu_req_q1 = '0;
        if (core_req.valid) begin
            lu_req_q1.valid         = 1'b1;
            lu_req_q1.lu_op         = (core_req.opcode == WR_OP) ? WR_LU : RD_LU;
            lu_req_q1.address       = core_req.address;
            lu_req_q1.data          = core_req.data;
            lu_req_q1.tq_id         = wr_hit_any ? encode(wr_hit_vec) : encode(alloc_vec);
            lu_req_q1.mb_hit_cancel = wr_hit_any;     // pipe drops it, the merge entry owns it
            lu_req_q1.rd_indication = (core_req.opcode == RD_OP);
            lu_req_q1.wr_indication = (core_req.opcode == WR_OP);
            lu_req_q1.reg_id        = core_req.reg_id;
        end else if (|fill_grant_vec) begin
            lu_req_q1.valid         = 1'b1;
            lu_req_q1.lu_op         = FILL_LU;
            lu_req_q1.address       = {mb_entries[fill_id].cl_address,
                                       mb_entries[fill_id].word_offset, 2'b00};
            lu_req_q1.cl_data       = mb_entries[fill_id].cl_data;
            lu_req_q1.tq_id         = fill_id;
            lu_req_q1.rd_indication = mb_entries[fill_id].rd_indication;
            lu_req_q1.wr_indication = mb_entries[fill_id].wr_indication;
            lu_req_q1.reg_id        = mb_entries[fill_id].reg_id;
        end
    end

    // ==============================
    // lookup response q3
    // ==============================
    assign core_lu_rsp = lu_rsp_q3.valid
                         && ((lu_rsp_q3.lu_op == RD_LU) || (lu_rsp_q3.lu_op == WR_LU));

    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            lu_hit_vec[i]  = core_lu_rsp && (lu_rsp_q3.tq_id == t_tq_id'(i))
                             && (lu_rsp_q3.lu_result == HIT);
            lu_miss_vec[i] = core_lu_rsp && (lu_rsp_q3.tq_id == t_tq_id'(i))
                             && (lu_rsp_q3.lu_result == MISS);
        end
    end

    assign rd_hit_rsp  = core_lu_rsp && (lu_rsp_q3.lu_op == RD_LU) && (lu_rsp_q3.lu_result == HIT);
    assign fill_rd_rsp = lu_rsp_q3.valid && (lu_rsp_q3.lu_op == FILL_LU)
                         && lu_rsp_q3.rd_indication;     // read miss finally served

    assign core_rsp.valid   = rd_hit_rsp || fill_rd_rsp;
    assign core_rsp.data    = lu_rsp_q3.cl_data[lu_rsp_q3.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET]];
    assign core_rsp.address = lu_rsp_q3.address;
    assign core_rsp.reg_id  = lu_rsp_q3.reg_id;

endmodule

`default_nettype wire

// ==== tq_merge_buffer.sv ====
// transaction queue merge buffer
// per-entry line data, written-word mask and request fields, write-merge detect
`default_nettype none

module tq_merge_buffer (
    input  wire                    clk,
    input  var tq_pkg::t_core_req  core_req,
    input  var tq_pkg::t_entry_vec alloc_vec,
    input  var tq_pkg::t_entry_vec merge_ok_vec,
    input  var tq_pkg::t_entry_vec fill_load_vec,
    input  var tq_pkg::t_fm_rsp    fm_rsp,
    output tq_pkg::t_entry_vec     wr_hit_vec,
    output tq_pkg::t_mb_entry [tq_pkg::NUM_TQ_ENTRY-1:0] mb_entries
);
    import tq_pkg::*;

    t_mb_entry [NUM_TQ_ENTRY-1:0] mb_nxt;
    t_entry_vec   wr_match_vec;
    t_cl_address  req_cl_address;
    t_word_offset req_offset;
    logic         req_wr;

    assign req_cl_address = core_req.address[MSB_CL_ADDR:LSB_CL_ADDR];
    assign req_offset     = core_req.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET];
    assign req_wr         = core_req.valid && (core_req.opcode == WR_OP);

    // ==============================
    // write merge detect
    // ==============================
    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            wr_match_vec[i] = req_wr
                              && (mb_entries[i].cl_address == req_cl_address)
                              && !mb_entries[i].rd_indication   // read entries never take merges
                              && merge_ok_vec[i];
        end
    end

    // two write entries can own the same line, merge into the lowest one
    assign wr_hit_vec = first_one(wr_match_vec);

    // ==============================
    // entry update
    // ==============================
    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            mb_nxt[i] = mb_entries[i];
            if (alloc_vec[i]) begin
                mb_nxt[i].cl_address    = req_cl_address;
                mb_nxt[i].word_offset   = req_offset;
                mb_nxt[i].reg_id        = core_req.reg_id;
                mb_nxt[i].rd_indication = (core_req.opcode == RD_OP);
                mb_nxt[i].wr_indication = (core_req.opcode == WR_OP);
                mb_nxt[i].mask          = '0;          // fresh line, nothing written yet
            end
            if ((alloc_vec[i] && req_wr) || wr_hit_vec[i]) begin
                mb_nxt[i].cl_data[req_offset] = core_req.data;
                mb_nxt[i].mask[req_offset]    = 1'b1;
            end
            // fill goes under the updated mask so a same-cycle write survives
            if (fill_load_vec[i]) begin
                for (int w = 0; w < WORDS_IN_CL; w++) begin
                    if (!mb_nxt[i].mask[w]) mb_nxt[i].cl_data[w] = fm_rsp.cl_data[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        mb_entries <= mb_nxt;
    end

endmodule

`default_nettype wire

// ==== tq_occupancy.sv ====
// transaction queue occupancy
// registered busy-entry count, stall once at most one entry is left free
`default_nettype none

module tq_occupancy (
    input  wire                    clk,
    input  wire                    rst_n,
    input  var tq_pkg::t_entry_vec alloc_vec,
    input  var tq_pkg::t_entry_vec retire_vec,
    input  wire                    core_valid,
    output logic                   stall
);
    import tq_pkg::*;

    t_count count;
    t_count count_nxt;

    // retire may carry a hit and a fill grant in the same cycle
    assign count_nxt = count + t_count'($countones(alloc_vec))
                             - t_count'($countones(retire_vec));

    always_ff @(posedge clk) begin
        if (!rst_n) count <= '0;
        else        count <= count_nxt;
    end

    assign stall = (count >= t_count'(NUM_TQ_ENTRY - 1));

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= t_count'(NUM_TQ_ENTRY));

    // core side must hold off while stalled
    a_no_req_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !core_valid);

endmodule

`default_nettype wire

// ==== tq_entry_fsm.sv ====
// transaction queue entry control
// one state machine per entry, lowest-free allocation and fill arrival decode
`default_nettype none

module tq_entry_fsm (
    input  wire                   clk,
    input  wire                   rst_n,
    input  var tq_pkg::t_core_req  core_req,
    input  var tq_pkg::t_entry_vec wr_hit_vec,
    input  var tq_pkg::t_entry_vec lu_hit_vec,
    input  var tq_pkg::t_entry_vec lu_miss_vec,
    input  var tq_pkg::t_entry_vec fill_grant_vec,
    input  var tq_pkg::t_fm_rsp    fm_rsp,
    output tq_pkg::t_entry_vec     alloc_vec,
    output tq_pkg::t_entry_vec     retire_vec,
    output tq_pkg::t_entry_vec     fill_ready_vec,
    output tq_pkg::t_entry_vec     merge_ok_vec,
    output tq_pkg::t_entry_vec     fill_load_vec
);
    import tq_pkg::*;

    t_tq_state  state     [NUM_TQ_ENTRY];
    t_tq_state  state_nxt [NUM_TQ_ENTRY];
    t_entry_vec idle_vec;
    t_entry_vec lu_core_vec;
    t_entry_vec wait_fill_vec;

    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            idle_vec[i]       = (state[i] == S_IDLE);
            lu_core_vec[i]    = (state[i] == S_LU_CORE);
            wait_fill_vec[i]  = (state[i] == S_MB_WAIT_FILL);
            fill_ready_vec[i] = (state[i] == S_MB_FILL_READY);
            fill_load_vec[i]  = wait_fill_vec[i] && fm_rsp.valid
                                && (fm_rsp.tq_id == t_tq_id'(i)); // fill for this entry
        end
    end

    // a merging write reuses its entry, no new allocation
    assign alloc_vec    = (core_req.valid && !(|wr_hit_vec)) ? first_one(idle_vec) : '0;
    assign merge_ok_vec = wait_fill_vec | fill_ready_vec;  // line already owned by memory request
    assign retire_vec   = (lu_core_vec & lu_hit_vec) | (fill_ready_vec & fill_grant_vec);

    // ==============================
    // next state
    // ==============================
    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            state_nxt[i] = state[i];
            unique case (state[i])
                S_IDLE:          if (alloc_vec[i]) state_nxt[i] = S_LU_CORE;
                S_LU_CORE: begin
                    if (lu_hit_vec[i])       state_nxt[i] = S_IDLE;          // done
                    else if (lu_miss_vec[i]) state_nxt[i] = S_MB_WAIT_FILL;  // go to far memory
                end
                S_MB_WAIT_FILL:  if (fill_load_vec[i])  state_nxt[i] = S_MB_FILL_READY;
                S_MB_FILL_READY: if (fill_grant_vec[i]) state_nxt[i] = S_IDLE;
                default:         state_nxt[i] = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            if (!rst_n) state[i] <= S_IDLE;
            else        state[i] <= state_nxt[i];
        end
    end

    // pipe port grants only entries this block reports as fill-ready
    a_grant_fill_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (fill_grant_vec & ~fill_ready_vec) == '0);

    // pipe responses only come back for entries still waiting on a core lookup
    a_rsp_in_lookup: assert property (@(posedge clk) disable iff (!rst_n)
        ((lu_hit_vec | lu_miss_vec) & ~lu_core_vec) == '0);

endmodule

`default_nettype wire

// ==== tq_pkg.sv ====
// data cache transaction queue package
// sizes, field types, state encodings and port bundles of the queue
`default_nettype none

package tq_pkg;

    // ==============================
    // sizes and address layout
    // ==============================
    localparam int NUM_TQ_ENTRY    = 4;
    localparam int WORDS_IN_CL     = 4;
    localparam int WORD_W          = 32;
    localparam int ADDR_W          = 20;
    localparam int LSB_WORD_OFFSET = 2;                 // bits 1..0 are the byte offset
    localparam int MSB_WORD_OFFSET = 3;
    localparam int LSB_CL_ADDR     = 4;
    localparam int MSB_CL_ADDR     = ADDR_W - 1;
    localparam int TQ_ID_W         = $clog2(NUM_TQ_ENTRY);
    localparam int REG_ID_W        = 5;
    localparam int CNT_W           = $clog2(NUM_TQ_ENTRY + 1); // 0..NUM_TQ_ENTRY

    typedef logic [WORD_W-1:0]                      t_word;
    typedef logic [WORDS_IN_CL-1:0][WORD_W-1:0]     t_cl;     // word 0 in the low bits
    typedef logic [ADDR_W-1:0]                      t_address;
    typedef logic [MSB_CL_ADDR-LSB_CL_ADDR:0]       t_cl_address;
    typedef logic [MSB_WORD_OFFSET-LSB_WORD_OFFSET:0] t_word_offset;
    typedef logic [WORDS_IN_CL-1:0]                 t_word_mask;
    typedef logic [TQ_ID_W-1:0]                     t_tq_id;
    typedef logic [NUM_TQ_ENTRY-1:0]                t_entry_vec;
    typedef logic [REG_ID_W-1:0]                    t_reg_id;
    typedef logic [CNT_W-1:0]                       t_count;

    // ==============================
    // encodings
    // ==============================
    typedef enum logic [0:0] {RD_OP, WR_OP} t_opcode;
    typedef enum logic [1:0] {NO_LU, RD_LU, WR_LU, FILL_LU} t_lu_op;
    typedef enum logic [0:0] {HIT, MISS} t_lu_result;
    typedef enum logic [1:0] {S_IDLE, S_LU_CORE, S_MB_WAIT_FILL, S_MB_FILL_READY} t_tq_state;

    // ==============================
    // port bundles
    // ==============================
    typedef struct packed {
        logic     valid;
        t_opcode  opcode;
        t_address address;
        t_word    data;
        t_reg_id  reg_id;
    } t_core_req;

    typedef struct packed {
        logic     valid;
        t_word    data;
        t_address address;
        t_reg_id  reg_id;
    } t_core_rsp;

    typedef struct packed {
        logic   valid;
        t_tq_id tq_id;
        t_cl    cl_data;
    } t_fm_rsp;

    typedef struct packed {
        logic     valid;
        t_lu_op   lu_op;
        t_address address;
        t_word    data;             // core write word
        t_cl      cl_data;          // merged line, fill lookups only
        t_tq_id   tq_id;
        logic     mb_hit_cancel;    // write merged into an entry, no pipe response expected
        logic     rd_indication;
        logic     wr_indication;
        t_reg_id  reg_id;
    } t_lu_req;

    typedef struct packed {
        logic       valid;
        t_lu_op     lu_op;
        t_lu_result lu_result;
        t_tq_id     tq_id;
        t_address   address;
        t_cl        cl_data;
        logic       rd_indication;
        t_reg_id    reg_id;
    } t_lu_rsp;

    typedef struct packed {
        t_cl          cl_data;
        t_word_mask   mask;         // words written by the core
        t_cl_address  cl_address;
        t_word_offset word_offset;
        t_reg_id      reg_id;
        logic         rd_indication;
        logic         wr_indication;
    } t_mb_entry;

    // keep only the lowest set bit
    function automatic t_entry_vec first_one(t_entry_vec v);
        return v & (~v + t_entry_vec'(1));
    endfunction

    // one-hot to index, lowest bit wins
    function automatic t_tq_id encode(t_entry_vec v);
        t_tq_id id;
        id = '0;
        for (int i = NUM_TQ_ENTRY - 1; i >= 0; i--) begin
            if (v[i]) id = t_tq_id'(i);
        end
        return id;
    endfunction

endpackage

`default_nettype wire
